//--- source/ppu_pkg.sv
package ppu_pkg;

    ////////////////////////////////////////////////////////////
    // Line and frame timing
    ////////////////////////////////////////////////////////////
    localparam logic [15:0] H_TOTAL  = 16'd456; // Cycles per line
    localparam logic [7:0]  V_TOTAL  = 8'd154;  // Lines per frame
    localparam logic [7:0]  V_ACTIVE = 8'd144;
    localparam logic [7:0]  H_OAM    = 8'd80;   // Mode 2 length
    localparam logic [7:0]  H_XFER   = 8'd168;  // Mode 3 length
    localparam logic [7:0]  H_PIXELS = 8'd160;
    localparam logic [7:0]  HS_START = 8'd76;
    localparam logic [7:0]  HS_LEN   = 8'd4;
    localparam logic [7:0]  VS_LINE  = 8'd153;

    ////////////////////////////////////////////////////////////
    // Bus map
    ////////////////////////////////////////////////////////////
    localparam logic [15:0] REG_LCDC  = 16'hFF40;
    localparam logic [15:0] REG_STAT  = 16'hFF41;
    localparam logic [15:0] REG_SCY   = 16'hFF42;
    localparam logic [15:0] REG_SCX   = 16'hFF43;
    localparam logic [15:0] REG_LY    = 16'hFF44;
    localparam logic [15:0] REG_BGP   = 16'hFF47;
    localparam logic [15:0] VRAM_BASE = 16'h8000;
    localparam logic [15:0] VRAM_LAST = 16'h9FFF;

    // Offsets inside video RAM
    localparam logic [12:0] MAP0          = 13'h1800;
    localparam logic [12:0] MAP1          = 13'h1C00;
    localparam logic [12:0] TILE_UNSIGNED = 13'h0000;
    localparam logic [12:0] TILE_SIGNED   = 13'h1000; // Signed tile id around this point

    localparam logic [7:0] BGP_RESET = 8'hFC;

    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_OAM    = 2'd2,
        MODE_XFER   = 2'd3
    } ppu_mode_e;

    typedef enum logic [3:0] {
        F_MAP_ADDR, F_MAP_READ, F_LO_ADDR, F_LO_READ,
        F_HI_ADDR, F_HI_READ, F_WAIT, F_PUSH, F_IDLE
    } fetch_state_e;

endpackage

//--- source/ppu_timing.sv
`timescale 1ns/10ps

module ppu_timing (
    input  logic                clk,
    input  logic                rst,
    input  logic                lcd_en,
    output ppu_pkg::ppu_mode_e  mode,
    output logic [7:0]          ly,
    output logic                xfer_start,
    output logic                hs,
    output logic                vs
);
    import ppu_pkg::*;

    logic [15:0] h_cnt; // Dot within the line
    logic [7:0]  v_cnt; // Line within the frame

    always_ff @(posedge clk)
    begin
        if (rst || !lcd_en)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == H_TOTAL - 1)
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_TOTAL - 1) ? 8'd0 : v_cnt + 8'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 16'd1;
        end
    end

    // Mode follows directly from the counters
    always_comb
    begin
        if (!lcd_en)
            mode = MODE_HBLANK;
        else if (v_cnt >= V_ACTIVE)
            mode = MODE_VBLANK;
        else if (h_cnt < H_OAM)
            mode = MODE_OAM;
        else if (h_cnt < H_OAM + H_XFER)
            mode = MODE_XFER;
        else
            mode = MODE_HBLANK;
    end

    assign ly         = v_cnt;
    assign xfer_start = lcd_en && (v_cnt < V_ACTIVE) && (h_cnt == H_OAM); // First xfer dot
    assign hs         = lcd_en && (h_cnt >= HS_START) && (h_cnt < HS_START + HS_LEN);
    assign vs         = lcd_en && (v_cnt == VS_LINE);

endmodule

//--- source/ppu_regs.sv
`timescale 1ns/10ps

module ppu_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        a,
    input  logic [7:0]         d_wr,
    input  logic               rd,
    input  logic               wr,
    input  ppu_pkg::ppu_mode_e mode,
    input  logic [7:0]         ly,
    input  logic [7:0]         vram_q,
    output logic [7:0]         d_rd,
    output logic               cpu_vram_sel,
    output logic               lcd_en,
    output logic               map_sel,
    output logic               tile_sel,
    output logic [7:0]         scx,
    output logic [7:0]         scy,
    output logic [7:0]         bgp
);
    import ppu_pkg::*;

    logic [7:0] lcdc;
    logic [7:0] reg_q;     // Register read value for current address
    logic       vram_ok;   // CPU may touch video RAM this cycle
    logic       vram_pend; // Video RAM read data arrives this cycle
    logic [7:0] rd_hold;

    assign cpu_vram_sel = (a >= VRAM_BASE) && (a <= VRAM_LAST);
    assign vram_ok      = cpu_vram_sel && (mode != MODE_XFER);

    assign lcd_en   = lcdc[7];
    assign tile_sel = lcdc[4]; // 1 = unsigned ids from 0000
    assign map_sel  = lcdc[3]; // 1 = map at 1C00

    always_comb
    begin
        case (a)
            REG_LCDC: reg_q = lcdc;
            REG_STAT: reg_q = {6'b000000, mode}; // Mode bits only
            REG_SCY:  reg_q = scy;
            REG_SCX:  reg_q = scx;
            REG_LY:   reg_q = ly;
            REG_BGP:  reg_q = bgp;
            default:  reg_q = 8'hFF;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcdc      <= 8'h00;
            scy       <= 8'h00;
            scx       <= 8'h00;
            bgp       <= BGP_RESET;
            vram_pend <= 1'b0;
        end
        else
        begin
            vram_pend <= rd && vram_ok;
            if (wr)
            begin
                case (a)
                    REG_LCDC: lcdc <= d_wr;
                    REG_SCY:  scy  <= d_wr;
                    REG_SCX:  scx  <= d_wr;
                    REG_BGP:  bgp  <= d_wr;
                    default:  ; // STAT mode and LY are read-only
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data path
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (vram_pend)
            rd_hold <= vram_q; // Keep RAM byte after its cycle
        if (rd && !vram_ok)
            rd_hold <= cpu_vram_sel ? 8'hFF : reg_q; // Blocked during xfer
    end

    // RAM data is one cycle late, so pass it straight through once
    assign d_rd = vram_pend ? vram_q : rd_hold;

endmodule

//--- source/ppu_vram.sv
`timescale 1ns/10ps

module ppu_vram (
    input  logic               clk,
    input  logic [12:0]        a13,
    input  logic [7:0]         d_wr,
    input  logic               wr,
    input  logic               cpu_vram_sel,
    input  ppu_pkg::ppu_mode_e mode,
    input  logic [12:0]        fetch_addr,
    output logic [7:0]         vram_q
);
    import ppu_pkg::*;

    logic [7:0]  mem [0:8191];
    logic [12:0] addr;
    logic        we;
    logic        fetch_owns; // Fetcher has the port in mode 3

    assign fetch_owns = (mode == MODE_XFER);
    assign addr       = fetch_owns ? fetch_addr : a13;
    assign we         = wr && cpu_vram_sel && !fetch_owns;

    // Single port, read data one cycle after the address
    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= d_wr;
        vram_q <= mem[addr];
    end

endmodule

//--- source/ppu_bg_fetcher.sv
`timescale 1ns/10ps

module ppu_bg_fetcher (
    input  logic        clk,
    input  logic        rst,
    input  logic        xfer_start,
    input  logic [7:0]  ly,
    input  logic [7:0]  scx,
    input  logic [7:0]  scy,
    input  logic        map_sel,
    input  logic        tile_sel,
    input  logic [7:0]  vram_q,
    output logic [12:0] fetch_addr,
    output logic        push,
    output logic [7:0]  row_lo,
    output logic [7:0]  row_hi
);
    import ppu_pkg::*;

    localparam logic [4:0] LAST_COL = 5'(H_PIXELS / 8 - 1);

    fetch_state_e state;
    fetch_state_e cur;      // Step being executed this cycle
    fetch_state_e nxt;
    logic [4:0]   col;
    logic [4:0]   col_eff;
    logic [7:0]   tile_id;
    logic [7:0]   y_pos;    // Line inside the 256 pixel map
    logic [4:0]   x_tile;
    logic [12:0]  map_addr;
    logic [12:0]  lo_addr;

    // Line start overrides whatever the fetcher was doing
    assign cur     = xfer_start ? F_MAP_ADDR : state;
    assign col_eff = xfer_start ? 5'd0 : col;

    ////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////
    assign y_pos    = ly + scy;
    assign x_tile   = col_eff + scx[7:3]; // Wraps at 32 tiles
    assign map_addr = (map_sel ? MAP1 : MAP0) + {3'b000, y_pos[7:3], x_tile};
    assign lo_addr  = (tile_sel ? TILE_UNSIGNED : TILE_SIGNED)
                    + {(tile_sel ? 1'b0 : tile_id[7]), tile_id, y_pos[2:0], 1'b0};

    always_comb
    begin
        case (cur)
            F_LO_ADDR: fetch_addr = lo_addr;
            F_HI_ADDR: fetch_addr = {lo_addr[12:1], 1'b1}; // Hi plane follows lo
            default:   fetch_addr = map_addr;
        endcase
    end

    always_comb
    begin
        case (cur)
            F_MAP_ADDR: nxt = F_MAP_READ;
            F_MAP_READ: nxt = F_LO_ADDR;
            F_LO_ADDR:  nxt = F_LO_READ;
            F_LO_READ:  nxt = F_HI_ADDR;
            F_HI_ADDR:  nxt = F_HI_READ;
            F_HI_READ:  nxt = F_WAIT;
            F_WAIT:     nxt = F_PUSH;
            F_PUSH:     nxt = (col_eff == LAST_COL) ? F_IDLE : F_MAP_ADDR;
            default:    nxt = F_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= F_IDLE;
            col   <= '0;
        end
        else
        begin
            state <= nxt;
            if (xfer_start)
                col <= '0;
            else if (cur == F_PUSH)
                col <= (col == LAST_COL) ? 5'd0 : col + 5'd1;
        end
    end

    // Fetched bytes
    always_ff @(posedge clk)
    begin
        case (cur)
            F_MAP_READ: tile_id <= vram_q;
            F_LO_READ:  row_lo  <= vram_q;
            F_HI_READ:  row_hi  <= vram_q;
            default:    ;
        endcase
    end

    assign push = (cur == F_PUSH);

endmodule

//--- source/ppu_pixel_fifo.sv
`timescale 1ns/10ps

module ppu_pixel_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       xfer_start,
    input  logic       push,
    input  logic [7:0] row_lo,
    input  logic [7:0] row_hi,
    input  logic [7:0] bgp,
    output logic [1:0] pixel,
    output logic       valid
);

    logic [31:0] store;   // 16 colour indices, head in the top bits
    logic [4:0]  count;
    logic        shift;
    logic [4:0]  base;    // Fill level after this cycle's shift
    logic [15:0] row_pix;

    assign shift = (count != 5'd0);
    assign valid = shift;
    assign base  = count - {4'b0000, shift};

    // Leftmost pixel of the row is bit 7 of each plane
    always_comb
    begin
        for (int j = 0; j < 8; j++)
            row_pix[15 - 2 * j -: 2] = {row_hi[7 - j], row_lo[7 - j]};
    end

    always_ff @(posedge clk)
    begin
        if (rst || xfer_start)
        begin
            count <= '0;
            store <= '0;
        end
        else
        begin
            count <= base + (push ? 5'd8 : 5'd0);
            if (push)
                store <= (shift ? store << 2 : store) | ({row_pix, 16'h0000} >> {base, 1'b0});
            else if (shift)
                store <= store << 2; // Zeros refill the tail
        end
    end

    assign pixel = bgp[{store[31:30], 1'b0} +: 2]; // Palette lookup

endmodule

//--- source/ppu.sv
`timescale 1ns/10ps

module ppu (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] a,
    input  logic [7:0]  d_wr,
    input  logic        rd,
    input  logic        wr,
    output logic [7:0]  d_rd,
    output logic [1:0]  pixel,
    output logic        valid,
    output logic        hs,
    output logic        vs
);
    import ppu_pkg::*;

    ppu_mode_e   mode;
    logic [7:0]  ly;
    logic        xfer_start;
    logic        lcd_en;
    logic        map_sel;
    logic        tile_sel;
    logic [7:0]  scx;
    logic [7:0]  scy;
    logic [7:0]  bgp;
    logic        cpu_vram_sel;
    logic [7:0]  vram_q;
    logic [12:0] fetch_addr;
    logic        push;
    logic [7:0]  row_lo;
    logic [7:0]  row_hi;

    ppu_timing u_timing (
        .clk(clk), .rst(rst), .lcd_en(lcd_en), .mode(mode), .ly(ly),
        .xfer_start(xfer_start), .hs(hs), .vs(vs)
    );

    // CPU side
    ppu_regs u_regs (
        .clk(clk), .rst(rst), .a(a), .d_wr(d_wr), .rd(rd), .wr(wr),
        .mode(mode), .ly(ly), .vram_q(vram_q), .d_rd(d_rd),
        .cpu_vram_sel(cpu_vram_sel), .lcd_en(lcd_en), .map_sel(map_sel),
        .tile_sel(tile_sel), .scx(scx), .scy(scy), .bgp(bgp)
    );

    ppu_vram u_vram (
        .clk(clk), .a13(a[12:0]), .d_wr(d_wr), .wr(wr), .cpu_vram_sel(cpu_vram_sel),
        .mode(mode), .fetch_addr(fetch_addr), .vram_q(vram_q)
    );

    ////////////////////////////////////////////////////////////
    // Pixel pipeline
    ////////////////////////////////////////////////////////////
    ppu_bg_fetcher u_fetcher (
        .clk(clk), .rst(rst), .xfer_start(xfer_start), .ly(ly), .scx(scx), .scy(scy),
        .map_sel(map_sel), .tile_sel(tile_sel), .vram_q(vram_q),
        .fetch_addr(fetch_addr), .push(push), .row_lo(row_lo), .row_hi(row_hi)
    );

    ppu_pixel_fifo u_fifo (
        .clk(clk), .rst(rst), .xfer_start(xfer_start), .push(push),
        .row_lo(row_lo), .row_hi(row_hi), .bgp(bgp), .pixel(pixel), .valid(valid)
    );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0; // Released just after the edge, like the bus inputs
    end

endmodule

//--- tb/tb_ppu.sv
`timescale 1ns/10ps

module tb_ppu;

    localparam int  LINE_CYCLES    = 456;
    localparam int  FRAME_LINES    = 154;
    localparam int  VIS_LINES      = 144;
    localparam int  LINE_PIXELS    = 160;
    localparam int  FRAME_CYCLES   = LINE_CYCLES * FRAME_LINES;
    localparam int  TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 40_000; // Three frames plus bus phases
    localparam time DRIVE_DELAY    = 1;

    logic        clk;
    logic        rst;
    logic [15:0] a;
    logic [7:0]  d_wr;
    logic        rd;
    logic        wr;
    logic [7:0]  d_rd;
    logic [1:0]  pixel;
    logic        valid;
    logic        hs;
    logic        vs;

    logic [1:0] frame_buf [0:VIS_LINES-1][0:LINE_PIXELS-1];
    int         line_pix [0:VIS_LINES-1]; // Valid pixels seen per line
    int         line_idx;
    int         col_idx;
    int         hs_in_frame;
    int         vs_len;
    int         vs_count;
    logic       hs_q;
    logic       vs_q;
    int         cycle_count;
    int         checks;
    int         value_errors;
    int         other_errors;

    clk_gen #(.PERIOD(4.0), .RST_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

    ppu DUT (
        .clk(clk), .rst(rst), .a(a), .d_wr(d_wr), .rd(rd), .wr(wr), .d_rd(d_rd),
        .pixel(pixel), .valid(valid), .hs(hs), .vs(vs)
    );

    ////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        a    = addr;
        d_wr = data;
        wr   = 1'b1;
        @(posedge clk); // Write lands here
        #DRIVE_DELAY;
        wr   = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        a  = addr;
        rd = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rd = 1'b0;
        @(negedge clk); // Data settled in the cycle after the rd edge
        data = d_rd;
    endtask

    task automatic check_byte(input logic [15:0] addr, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t ns: read of %h gave %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_pixel(input int ln, input int col, input int exp);
        checks++;
        if (ln < 0 || ln >= VIS_LINES || col < 0 || col >= LINE_PIXELS)
        begin
            other_errors++;
            $display("trace asks for pixel %0d,%0d which is off the screen", ln, col);
        end
        else if (frame_buf[ln][col] !== exp[1:0])
        begin
            value_errors++;
            $display("error at %0t ns: pixel line %0d column %0d is %0d, expected %0d",
                     $time, ln, col, frame_buf[ln][col], exp);
        end
    endtask

    // Start of the next run of valid pixels in mode 3
    task automatic wait_pixels;
        @(negedge clk);
        while (valid)
            @(negedge clk);
        while (!valid)
            @(negedge clk);
    endtask

    task automatic wait_frame;
        int target;
        target = vs_count + 1;
        while (vs_count < target)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // LCD side capture
    ////////////////////////////////////////////////////////////
    task automatic check_frame;
        for (int l = 0; l < VIS_LINES; l++)
        begin
            if (line_pix[l] != LINE_PIXELS)
            begin
                value_errors++;
                $display("error at %0t ns: line %0d carried %0d pixels, expected %0d",
                         $time, l, line_pix[l], LINE_PIXELS);
            end
            line_pix[l] = 0;
        end
        checks++;
        if (vs_count > 0 && hs_in_frame != FRAME_LINES)
        begin
            value_errors++;
            $display("error at %0t ns: %0d hs pulses in the frame, expected %0d",
                     $time, hs_in_frame, FRAME_LINES);
        end
        hs_in_frame = 0;
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            line_idx    = -1;
            col_idx     = 0;
            hs_in_frame = 0;
            vs_len      = 0;
            vs_count    = 0;
            hs_q        = 1'b0;
            vs_q        = 1'b0;
            for (int l = 0; l < VIS_LINES; l++)
                line_pix[l] = 0;
        end
        else
        begin
            if (hs && !hs_q)
            begin
                line_idx++; // hs comes before the pixels of its line
                col_idx = 0;
                hs_in_frame++;
            end
            if (valid)
            begin
                if (line_idx >= 0 && line_idx < VIS_LINES && col_idx < LINE_PIXELS)
                begin
                    frame_buf[line_idx][col_idx] = pixel;
                    line_pix[line_idx]++;
                end
                else
                begin
                    other_errors++;
                    $display("a valid pixel appeared outside the visible area at %0t ns", $time);
                end
                col_idx++;
            end
            if (vs && !vs_q)
            begin
                check_frame();
                vs_len = 0;
                vs_count++;
            end
            if (!vs && vs_q)
            begin
                checks++;
                if (vs_len != LINE_CYCLES)
                begin
                    value_errors++;
                    $display("error at %0t ns: vs was high for %0d cycles, expected %0d",
                             $time, vs_len, LINE_CYCLES);
                end
                line_idx = -1; // Next hs is line 0
            end
            if (vs)
                vs_len++;
            hs_q = hs;
            vs_q = vs;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the trace did not finish", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Trace player
    ////////////////////////////////////////////////////////////
    task automatic expect_fields(input logic [7:0] op, input int got, input int want);
        if (got != want)
        begin
            other_errors++;
            $display("trace record %c has %0d readable fields instead of %0d", op, got, want);
        end
    endtask

    task automatic run_trace(input int fd);
        int               code;
        logic [7:0]       op;
        logic [15:0]      addr;
        logic [7:0]       data;
        logic [7:0]       got;
        int               ln;
        int               col;
        int               pix;
        logic [8*128-1:0] rest;
        while ($fscanf(fd, " %c", op) == 1)
        begin
            case (op)
                "#":
                    code = $fgets(rest, fd); // Comment line
                "W":
                begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    expect_fields(op, code, 2);
                    bus_write(addr, data);
                end
                "R":
                begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    expect_fields(op, code, 2);
                    bus_read(addr, got);
                    check_byte(addr, got, data);
                end
                "X":
                begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    expect_fields(op, code, 2);
                    wait_pixels();
                    bus_read(addr, got);
                    check_byte(addr, got, data);
                end
                "B":
                begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    expect_fields(op, code, 2);
                    wait_pixels();
                    bus_write(addr, data);
                end
                "F":
                    wait_frame();
                "P":
                begin
                    code = $fscanf(fd, "%d %d %d", ln, col, pix);
                    expect_fields(op, code, 3);
                    check_pixel(ln, col, pix);
                end
                default:
                begin
                    other_errors++;
                    $display("unknown trace record type %c, line skipped", op);
                    code = $fgets(rest, fd);
                end
            endcase
        end
    endtask

    initial
    begin
        int fd;
        a            = 16'h0000;
        d_wr         = 8'h00;
        rd           = 1'b0;
        wr           = 1'b0;
        cycle_count  = 0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        @(negedge rst);
        fd = $fopen("tb/ppu_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file tb/ppu_trace.txt");
            $display("=== FAIL ===");
            $finish;
        end
        else
        begin
            run_trace(fd);
            $fclose(fd);
            $display("checks: %0d, value errors: %0d, other errors: %0d",
                     checks, value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

//--- ppu.f
source/ppu_pkg.sv
source/ppu_timing.sv
source/ppu_regs.sv
source/ppu_vram.sv
source/ppu_bg_fetcher.sv
source/ppu_pixel_fifo.sv
source/ppu.sv
tb/clk_gen.sv
tb/tb_ppu.sv

//--- Bender.yml
package:
  name: ppu

sources:
  - source/ppu_pkg.sv
  - source/ppu_timing.sv
  - source/ppu_regs.sv
  - source/ppu_vram.sv
  - source/ppu_bg_fetcher.sv
  - source/ppu_pixel_fifo.sv
  - source/ppu.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_ppu.sv

//--- tb/ppu_trace.txt
# W addr data | R addr expected | X addr expected (read in mode 3) | B addr data (write in mode 3)
# F (wait for next vs) | P line column pixel (decimal, frame just captured)
# Registers with the LCD off
R FF47 FC
W FF42 5A
R FF42 5A
W FF43 A5
R FF43 A5
W FF47 E4
R FF47 E4
W FF40 1B
R FF40 1B
W FF41 03
R FF41 00
W FF44 55
R FF44 00
R FF45 FF
# Map and tile bytes
W 9C42 01
W 9C43 02
W 8010 F0
W 8011 CC
W 8012 81
W 8013 00
W 8020 0F
W 8021 55
W 981F 00
W 9800 01
W 9000 AA
W 9001 0F
W 9010 3C
W 9011 F0
R 9C42 01
R 8011 CC
R 9001 0F
R 9010 3C
# Frame 1 with map 1C00, unsigned ids, scy 0A, scx 13
W FF42 0A
W FF43 13
W FF40 98
F
P 6 0 3
P 6 2 1
P 6 4 2
P 6 7 0
P 6 9 2
P 6 12 1
P 6 13 3
P 7 0 1
P 7 3 0
P 7 7 1
# Frame 2 with map 1800, signed ids, scroll wrapping
W FF40 80
W FF43 F8
W FF42 FE
F
P 2 0 1
P 2 5 2
P 2 6 3
P 2 10 3
P 2 12 1
# Frame 3 with a reversed palette and blocked VRAM access
W FF47 1B
X 9000 FF
B 9000 55
F
P 2 0 2
P 2 5 1
P 2 6 0
P 2 10 0
P 2 14 3
R 9000 AA
R FF47 1B
